/* Makefile */
TOP := fomu_pvt_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): fomu_pvt.f hdl/*.sv verification/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f fomu_pvt.f

# the log decides, a crashed run counts as failed too
test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "*** TEST FAILED ***" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* fomu_pvt.f */
hdl/fomu_pkg.sv
hdl/rgb_duty_if.sv
hdl/touch_debounce.sv
hdl/color_sequencer.sv
hdl/rgb_pwm.sv
hdl/fomu_pvt.sv
verification/fomu_pvt_properties.sv
verification/fomu_pvt_tb.sv

/* hdl/color_sequencer.sv */
`timescale 1ns/1ps

module color_sequencer (
  input  logic            clk_48MHz,
  input  logic            rst,
  input  fomu_pkg::pads_t press,   // one-cycle pulses from the debouncer
  rgb_duty_if.source      duty     // duties toward the pwm
);

  fomu_pkg::color_idx_t idx;       // current palette entry
  fomu_pkg::color_idx_t idx_n;
  fomu_pkg::level_t     level;     // brightness
  fomu_pkg::level_t     level_n;
  fomu_pkg::seq_state_t state;     // on / off
  fomu_pkg::seq_state_t state_n;
  fomu_pkg::color_t     color_n;   // palette colour after this cycle

  // dim a channel by one bit per level below max
  function automatic fomu_pkg::duty_t scale(input fomu_pkg::duty_t ch,
                                            input fomu_pkg::level_t lvl);
    return ch >> (fomu_pkg::LEVEL_MAX - lvl);
  endfunction

  // next colour index, opposite presses in one cycle cancel
  always_comb begin
    idx_n = idx;
    if (press[fomu_pkg::PAD_NEXT] && !press[fomu_pkg::PAD_PREV]) begin
      idx_n = fomu_pkg::color_idx_t'(idx + 1'b1);   // wraps 7 -> 0
    end else if (press[fomu_pkg::PAD_PREV] && !press[fomu_pkg::PAD_NEXT]) begin
      idx_n = fomu_pkg::color_idx_t'(idx - 1'b1);   // wraps 0 -> 7
    end
  end

  // brightness and on/off
  always_comb begin
    level_n = level;
    state_n = state;
    if (press[fomu_pkg::PAD_LEVEL]) begin
      level_n = fomu_pkg::level_t'(level + 1'b1);   // 3 -> 0
    end
    if (press[fomu_pkg::PAD_POWER]) begin
      state_n = (state == fomu_pkg::seq_on) ? fomu_pkg::seq_off : fomu_pkg::seq_on;
    end
  end

  assign color_n = fomu_pkg::PALETTE[idx_n];

  // duties come from the next-state values so that state and duties
  // move together one cycle after the press
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      idx         <= '0;                       // white
      level       <= fomu_pkg::LEVEL_MAX;
      state       <= fomu_pkg::seq_on;
      duty.duty_r <= scale(fomu_pkg::PALETTE[0][fomu_pkg::RED_LSB +: fomu_pkg::DUTY_BITS],
                           fomu_pkg::LEVEL_MAX);
      duty.duty_g <= scale(fomu_pkg::PALETTE[0][fomu_pkg::GREEN_LSB +: fomu_pkg::DUTY_BITS],
                           fomu_pkg::LEVEL_MAX);
      duty.duty_b <= scale(fomu_pkg::PALETTE[0][fomu_pkg::BLUE_LSB +: fomu_pkg::DUTY_BITS],
                           fomu_pkg::LEVEL_MAX);
    end else begin
      idx   <= idx_n;
      level <= level_n;
      state <= state_n;
      if (state_n == fomu_pkg::seq_on) begin
        duty.duty_r <= scale(color_n[fomu_pkg::RED_LSB +: fomu_pkg::DUTY_BITS], level_n);
        duty.duty_g <= scale(color_n[fomu_pkg::GREEN_LSB +: fomu_pkg::DUTY_BITS], level_n);
        duty.duty_b <= scale(color_n[fomu_pkg::BLUE_LSB +: fomu_pkg::DUTY_BITS], level_n);
      end else begin
        duty.duty_r <= '0;   // dark but index and level kept
        duty.duty_g <= '0;
        duty.duty_b <= '0;
      end
    end
  end

endmodule

/* hdl/fomu_pkg.sv */
package fomu_pkg;

  localparam int NUM_PADS      = 4;    // touch pads on the board
  localparam int DUTY_BITS     = 8;    // pwm resolution per channel
  localparam int NUM_COLORS    = 8;    // palette entries
  localparam int DEBOUNCE_BITS = 16;   // 2**16 cycles stable, ~1.4 ms at 48 MHz

  // which pad does what
  localparam int PAD_NEXT  = 0;        // pad 1 steps the colour forward
  localparam int PAD_PREV  = 1;        // pad 2 steps it back
  localparam int PAD_LEVEL = 2;        // pad 3 cycles brightness
  localparam int PAD_POWER = 3;        // pad 4 toggles the light

  typedef logic [DUTY_BITS-1:0]          duty_t;       // one pwm duty / colour channel
  typedef logic [3*DUTY_BITS-1:0]        color_t;      // {red, green, blue}
  typedef logic [1:0]                    level_t;      // brightness 0..3
  typedef logic [NUM_PADS-1:0]           pads_t;       // bit 0 is pad 1
  typedef logic [$clog2(NUM_COLORS)-1:0] color_idx_t;  // palette index
  typedef logic [DEBOUNCE_BITS-1:0]      db_cnt_t;     // stable-sample counter

  localparam level_t LEVEL_MAX = 2'd3;  // full brightness

  // channel offsets inside color_t
  localparam int RED_LSB   = 2*DUTY_BITS;
  localparam int GREEN_LSB = DUTY_BITS;
  localparam int BLUE_LSB  = 0;

  localparam color_t PALETTE [NUM_COLORS] = '{
    24'hff_ff_ff,  // white
    24'hff_00_00,  // red
    24'h00_ff_00,  // green
    24'h00_00_ff,  // blue
    24'hff_ff_00,  // yellow
    24'h00_ff_ff,  // cyan
    24'hff_00_ff,  // magenta
    24'hff_80_00   // orange
  };

  // light on or off
  typedef enum logic {
    seq_on,
    seq_off
  } seq_state_t;

endpackage

/* hdl/fomu_pvt.sv */
`timescale 1ns/1ps

module fomu_pvt (
  input  logic clk_48MHz,   // 48 MHz oscillator, used unbuffered
  input  logic rst,

  input  logic touch_1,     // touch pads as plain inputs
  input  logic touch_2,
  input  logic touch_3,
  input  logic touch_4,

  output logic rgb_0,       // green
  output logic rgb_1,       // red
  output logic rgb_2,       // blue

  output logic usb_dp,      // usb d+
  output logic usb_dn,      // usb d-
  output logic usb_dp_pu    // d+ pull-up
);

  fomu_pkg::pads_t pads;    // pad 1 in bit 0
  fomu_pkg::pads_t press;
  logic            led_r;
  logic            led_g;
  logic            led_b;

  rgb_duty_if duty_bus ();

  assign pads = {touch_4, touch_3, touch_2, touch_1};

  touch_debounce u_debounce (
    .clk_48MHz (clk_48MHz),
    .rst       (rst),
    .pads      (pads),
    .press     (press)
  );

  color_sequencer u_sequencer (
    .clk_48MHz (clk_48MHz),
    .rst       (rst),
    .press     (press),
    .duty      (duty_bus.source)
  );

  rgb_pwm u_pwm (
    .clk_48MHz (clk_48MHz),
    .rst       (rst),
    .duty      (duty_bus.sink),
    .led_r     (led_r),
    .led_g     (led_g),
    .led_b     (led_b)
  );

  // same pin order as the led driver on the board
  assign rgb_0 = led_g;
  assign rgb_1 = led_r;
  assign rgb_2 = led_b;

  // no usb stack, keep the host from enumerating us
  assign usb_dp    = 1'b0;
  assign usb_dn    = 1'b0;
  assign usb_dp_pu = 1'b0;

endmodule

/* hdl/rgb_duty_if.sv */
`timescale 1ns/1ps

// duty levels from sequencer to pwm plus the frame marker going back
interface rgb_duty_if;

  fomu_pkg::duty_t duty_r;   // red duty
  fomu_pkg::duty_t duty_g;   // green duty
  fomu_pkg::duty_t duty_b;   // blue duty
  logic            frame_start;  // pwm counter at zero

  modport source (
    output duty_r,
    output duty_g,
    output duty_b,
    input  frame_start
  );

  modport sink (
    input  duty_r,
    input  duty_g,
    input  duty_b,
    output frame_start
  );

endinterface

/* hdl/rgb_pwm.sv */
`timescale 1ns/1ps

module rgb_pwm (
  input  logic     clk_48MHz,
  input  logic     rst,
  rgb_duty_if.sink duty,     // duties in, frame marker out
  output logic     led_r,    // active-high pwm
  output logic     led_g,
  output logic     led_b
);

  fomu_pkg::duty_t cnt;      // frame counter 0..255
  fomu_pkg::duty_t lat_r;    // duties held for the running frame
  fomu_pkg::duty_t lat_g;
  fomu_pkg::duty_t lat_b;
  fomu_pkg::duty_t nxt_r;    // what the latches hold next cycle
  fomu_pkg::duty_t nxt_g;
  fomu_pkg::duty_t nxt_b;

  assign duty.frame_start = (cnt == '0);

  // new duties only enter at the frame boundary
  assign nxt_r = duty.frame_start ? duty.duty_r : lat_r;
  assign nxt_g = duty.frame_start ? duty.duty_g : lat_g;
  assign nxt_b = duty.frame_start ? duty.duty_b : lat_b;

  // free-running counter, wraps at 256
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      lat_r <= '0;
      lat_g <= '0;
      lat_b <= '0;
    end else begin
      lat_r <= nxt_r;
      lat_g <= nxt_g;
      lat_b <= nxt_b;
    end
  end

  // compare against the incoming latch value so pin and latch agree
  // in every cycle, including the first of a frame
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      led_r <= 1'b0;
      led_g <= 1'b0;
      led_b <= 1'b0;
    end else begin
      led_r <= (cnt < nxt_r);   // high for nxt_r counts per frame
      led_g <= (cnt < nxt_g);
      led_b <= (cnt < nxt_b);
    end
  end

endmodule

/* hdl/touch_debounce.sv */
`timescale 1ns/1ps

module touch_debounce (
  input  logic            clk_48MHz,
  input  logic            rst,
  input  fomu_pkg::pads_t pads,   // raw pad levels, async
  output fomu_pkg::pads_t press   // one-cycle pulse per touch
);

  fomu_pkg::pads_t   sync_1;     // first sync stage
  fomu_pkg::pads_t   sync_2;     // second sync stage
  fomu_pkg::pads_t   level;      // debounced pad level
  fomu_pkg::pads_t   level_q;    // level one cycle back
  fomu_pkg::db_cnt_t cnt [fomu_pkg::NUM_PADS];  // per-pad stable counter

  // two-flop synchronizer
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= pads;
      sync_2 <= sync_1;
    end
  end

  // a pad has to disagree with the debounced level for 2**DEBOUNCE_BITS
  // samples in a row before the level follows
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      level <= '0;
      for (int i = 0; i < fomu_pkg::NUM_PADS; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < fomu_pkg::NUM_PADS; i++) begin
        if (sync_2[i] == level[i]) begin
          cnt[i] <= '0;                  // bounce back, start over
        end else if (&cnt[i]) begin
          level[i] <= sync_2[i];         // held long enough
          cnt[i]   <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // rising edge of the debounced level
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      level_q <= '0;
      press   <= '0;
    end else begin
      level_q <= level;
      press   <= level & ~level_q;   // lags the rise by one cycle
    end
  end

endmodule

/* verification/fomu_pvt_cases.txt */
# code red green blue; code is decimal: 0 no press, 1-4 press pad, 1x glitch on pad x,
# 2x bouncy press on pad x; duties in hex, red green blue as seen on the pins
0  ff ff ff
1  ff 00 00
1  00 ff 00
1  00 00 ff
1  ff ff 00
1  00 ff ff
1  ff 00 ff
1  ff 80 00
1  ff ff ff
2  ff 80 00
2  ff 00 ff
1  ff 80 00
# orange through all levels
3  1f 10 00
3  3f 20 00
3  7f 40 00
3  ff 80 00
3  1f 10 00
3  3f 20 00
# off, colour step while dark, back on at level 1
4  00 00 00
1  00 00 00
4  3f 3f 3f
# debounce
11 3f 3f 3f
14 3f 3f 3f
21 3f 00 00
23 7f 00 00
2  7f 7f 7f
3  ff ff ff

/* verification/fomu_pvt_properties.sv */
`timescale 1ns/1ps

// bound into the pwm and into the debouncer
module fomu_pvt_properties (
  input logic            clk_48MHz,
  input logic            rst,
  input fomu_pkg::pads_t press,   // debouncer pulses
  input fomu_pkg::duty_t cnt,     // pwm frame counter
  input fomu_pkg::duty_t lat_r,   // latched duties
  input fomu_pkg::duty_t lat_g,
  input fomu_pkg::duty_t lat_b,
  input logic            led_r,   // pwm outputs
  input logic            led_g,
  input logic            led_b
);

  int fail_count = 0;   // failed assertions in this instance

  // one single-cycle pulse per touch
  press_single: assert property (@(posedge clk_48MHz) disable iff (rst)
    (press & $past(press)) == '0)
    else begin
      $error("press bit high two cycles in a row");
      fail_count++;
    end

  // latches only load on the counter zero cycle
  lat_r_frame: assert property (@(posedge clk_48MHz) disable iff (rst)
    (lat_r != $past(lat_r)) |-> ($past(cnt) == '0))
    else begin
      $error("red duty latched outside frame start");
      fail_count++;
    end
  lat_g_frame: assert property (@(posedge clk_48MHz) disable iff (rst)
    (lat_g != $past(lat_g)) |-> ($past(cnt) == '0))
    else begin
      $error("green duty latched outside frame start");
      fail_count++;
    end
  lat_b_frame: assert property (@(posedge clk_48MHz) disable iff (rst)
    (lat_b != $past(lat_b)) |-> ($past(cnt) == '0))
    else begin
      $error("blue duty latched outside frame start");
      fail_count++;
    end

  // zero duty means a dark pin
  pin_r_dark: assert property (@(posedge clk_48MHz) disable iff (rst)
    led_r |-> (lat_r != '0))
    else begin
      $error("red pin high with zero duty");
      fail_count++;
    end
  pin_g_dark: assert property (@(posedge clk_48MHz) disable iff (rst)
    led_g |-> (lat_g != '0))
    else begin
      $error("green pin high with zero duty");
      fail_count++;
    end
  pin_b_dark: assert property (@(posedge clk_48MHz) disable iff (rst)
    led_b |-> (lat_b != '0))
    else begin
      $error("blue pin high with zero duty");
      fail_count++;
    end

  pins_after_rst: assert property (@(posedge clk_48MHz)
    rst |=> (!led_r && !led_g && !led_b))
    else begin
      $error("pins not low after reset");
      fail_count++;
    end

endmodule

bind rgb_pwm fomu_pvt_properties pwm_props (
  .clk_48MHz (clk_48MHz),
  .rst       (rst),
  .press     ('0),        // no pads in here
  .cnt       (cnt),
  .lat_r     (lat_r),
  .lat_g     (lat_g),
  .lat_b     (lat_b),
  .led_r     (led_r),
  .led_g     (led_g),
  .led_b     (led_b)
);

bind touch_debounce fomu_pvt_properties debounce_props (
  .clk_48MHz (clk_48MHz),
  .rst       (rst),
  .press     (press),
  .cnt       ('0),        // pwm side not visible from here
  .lat_r     ('0),
  .lat_g     ('0),
  .lat_b     ('0),
  .led_r     (1'b0),
  .led_g     (1'b0),
  .led_b     (1'b0)
);

/* verification/fomu_pvt_tb.sv */
`timescale 1ns/1ps

module fomu_pvt_tb;

  logic clk_48MHz;
  logic rst;
  logic touch_1;
  logic touch_2;
  logic touch_3;
  logic touch_4;
  logic rgb_0;       // green
  logic rgb_1;       // red
  logic rgb_2;       // blue
  logic usb_dp;
  logic usb_dn;
  logic usb_dp_pu;

  int              case_code [$];  // pad code per case
  fomu_pkg::duty_t case_r [$];     // expected duties
  fomu_pkg::duty_t case_g [$];
  fomu_pkg::duty_t case_b [$];

  int hold_cycles;     // twice the debounce time
  int glitch_cycles;   // well under the debounce time
  int bounce_cycles;   // one half of a bounce
  int cycle_cnt;
  int cycle_limit;
  int case_num;
  int duty_errors;
  int pin_errors;
  int assert_errors;   // summed from both bound checkers
  int other_errors;

  fomu_pvt dut (
    .clk_48MHz (clk_48MHz),
    .rst       (rst),
    .touch_1   (touch_1),
    .touch_2   (touch_2),
    .touch_3   (touch_3),
    .touch_4   (touch_4),
    .rgb_0     (rgb_0),
    .rgb_1     (rgb_1),
    .rgb_2     (rgb_2),
    .usb_dp    (usb_dp),
    .usb_dn    (usb_dn),
    .usb_dp_pu (usb_dp_pu)
  );

  initial begin
    clk_48MHz = 1'b0;
    forever #4 clk_48MHz = ~clk_48MHz;   // 8 ns period
  end

  // run guard with a limit set once the cases are known
  always @(posedge clk_48MHz) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: simulation ran past %0d cycles without finishing", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic load_cases();
    int              fd;
    int              code;
    int              n;
    string           line;
    fomu_pkg::duty_t r;
    fomu_pkg::duty_t g;
    fomu_pkg::duty_t b;
    fd = $fopen("verification/fomu_pvt_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/fomu_pvt_cases.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;   // blank or comment
      end
      n = $sscanf(line, "%d %h %h %h", code, r, g, b);
      if (n != 4) begin
        $display("malformed line in cases file: %s", line);
        other_errors++;
      end else begin
        case_code.push_back(code);
        case_r.push_back(r);
        case_g.push_back(g);
        case_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  // ends 1 ns past the n-th rising edge when inputs change
  task automatic idle(input int n);
    repeat (n) @(posedge clk_48MHz);
    #1;
  endtask

  task automatic drive_pad(input int pad, input logic val);
    case (pad)
      1: touch_1 = val;
      2: touch_2 = val;
      3: touch_3 = val;
      4: touch_4 = val;
      default: ;
    endcase
  endtask

  task automatic touch_pad(input int code);
    int pad;
    int kind;
    pad  = code % 10;
    kind = code / 10;   // 0 clean, 1 glitch, 2 bouncy
    if (pad == 0) begin
      return;
    end
    if (kind == 1) begin
      drive_pad(pad, 1'b1);
      idle(glitch_cycles);   // too short to pass the debouncer
    end else if (kind == 0 || kind == 2) begin
      if (kind == 2) begin
        repeat (4) begin     // contact bounce before the steady hold
          drive_pad(pad, 1'b1);
          idle(bounce_cycles);
          drive_pad(pad, 1'b0);
          idle(bounce_cycles);
        end
      end
      drive_pad(pad, 1'b1);
      idle(hold_cycles);
    end else begin
      $display("case %0d has an unknown pad code %0d", case_num, code);
      other_errors++;
    end
    drive_pad(pad, 1'b0);
    idle(hold_cycles);       // release settles too
  endtask

  task automatic check_duty(input string ch, input fomu_pkg::duty_t exp,
                            input fomu_pkg::duty_t got);
    if (got !== exp) begin
      duty_errors++;
      $display("ERROR at %0d ns: case %0d %s duty expected %02h measured %02h",
               $time, case_num, ch, exp, got);
    end
  endtask

  task automatic check_pin(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      pin_errors++;
      $display("ERROR at %0d ns: case %0d %s expected %b got %b",
               $time, case_num, name, exp, got);
    end
  endtask

  // a full frame high cannot come from any 8-bit duty
  task automatic check_high_count(input string ch, input int hi);
    if (hi > 255) begin
      $display("case %0d: %s pin stayed high for a whole frame", case_num, ch);
      other_errors++;
    end
  endtask

  task automatic measure_case(input int k);
    int hi_r;
    int hi_g;
    int hi_b;
    idle(512);   // new duty reaches the pins within one frame
    hi_r = 0;
    hi_g = 0;
    hi_b = 0;
    repeat (256) begin       // exactly one pwm period
      @(posedge clk_48MHz);
      #1;
      if (rgb_1 === 1'b1) hi_r++;
      if (rgb_0 === 1'b1) hi_g++;
      if (rgb_2 === 1'b1) hi_b++;
    end
    check_high_count("red", hi_r);
    check_high_count("green", hi_g);
    check_high_count("blue", hi_b);
    check_duty("red", case_r[k], fomu_pkg::duty_t'(hi_r));
    check_duty("green", case_g[k], fomu_pkg::duty_t'(hi_g));
    check_duty("blue", case_b[k], fomu_pkg::duty_t'(hi_b));
    check_pin("usb_dp", 1'b0, usb_dp);
    check_pin("usb_dn", 1'b0, usb_dn);
    check_pin("usb_dp_pu", 1'b0, usb_dp_pu);
  endtask

  initial begin
    rst           = 1'b1;
    touch_1       = 1'b0;
    touch_2       = 1'b0;
    touch_3       = 1'b0;
    touch_4       = 1'b0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    case_num      = 0;
    duty_errors   = 0;
    pin_errors    = 0;
    assert_errors = 0;
    other_errors  = 0;
    hold_cycles   = 2 << fomu_pkg::DEBOUNCE_BITS;
    glitch_cycles = 1000;
    bounce_cycles = 50;
    load_cases();
    if (case_code.size() == 0) begin
      $display("no cases found in the cases file");
      other_errors++;
    end
    cycle_limit = case_code.size() * (4 * (1 << fomu_pkg::DEBOUNCE_BITS) + 1024) + 1000;
    idle(2);     // two reset cycles
    rst = 1'b0;
    foreach (case_code[k]) begin
      case_num = k + 1;
      touch_pad(case_code[k]);
      measure_case(k);
    end
    assert_errors = dut.u_pwm.pwm_props.fail_count
                  + dut.u_debounce.debounce_props.fail_count;
    $display("errors: duty %0d, pin %0d, assert %0d, other %0d",
             duty_errors, pin_errors, assert_errors, other_errors);
    if (duty_errors + pin_errors + assert_errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
